// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_mem_subsystem
FILELIST  = mem_subsystem_top.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: common/mem_stage_macros.svh
// Memory stage width codes and cache sizing
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Access width codes in mem_width
`define MEMW_1 2'd0
`define MEMW_2 2'd1
`define MEMW_4 2'd2

// Number of cache lines as a power of two
`define DCACHE_LINES 16

// Address bits 31:28 of the SDRAM region
`define CACHEABLE_NIBBLE 4'h2

`endif

// File: common/mem_stage_pkg.sv
// Memory stage shared types
`default_nettype none

package mem_stage_pkg;

	// Executed instruction handed over by the execute stage
	typedef struct packed {
		logic        strobe;
		logic        mem_read;
		logic        mem_write;
		logic        mem_flush;
		logic [1:0]  mem_width;
		logic        mem_signed;
		logic [31:0] mem_address;
		logic [31:0] rd;
		logic [4:0]  inst_rd;
		logic [4:0]  mem_inst_rd;
	} execute_data_t;

	// Result handed to write-back
	typedef struct packed {
		logic        strobe;
		logic [31:0] rd;
		logic [4:0]  inst_rd;
	} memory_data_t;

	// Memory stage to data cache
	typedef struct packed {
		logic        request;
		logic        rw;
		logic        flush;
		logic        cacheable;
		logic [31:0] address;
		logic [31:0] wdata;
	} dcache_req_t;

	// Data cache to external bus
	typedef struct packed {
		logic        request;
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

endpackage

`default_nettype wire

// File: dcache/dcache_direct.sv
// Direct-mapped write-through data cache
`default_nettype none
`timescale 1ns/1ns

`include "mem_stage_macros.svh"

module dcache_direct
	import mem_stage_pkg::*;
(
	input  wire              i_clock,
	input  wire              i_rst,

	input  wire dcache_req_t i_req,
	output logic             o_ready,
	output logic [31:0]      o_rdata,

	output bus_req_t         o_bus,
	input  wire              i_bus_ready,
	input  wire [31:0]       i_bus_rdata,

	output logic [31:0]      o_hit,
	output logic [31:0]      o_miss
);

	localparam int INDEX_W = $clog2(`DCACHE_LINES);
	localparam int TAG_W = 30 - INDEX_W;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_BUS,
		ST_FILL,
		ST_FLUSH
	} state_t;

	logic [TAG_W-1:0]         tag_mem [`DCACHE_LINES];
	logic [31:0]              data_mem [`DCACHE_LINES];
	logic [`DCACHE_LINES-1:0] valid;

	state_t              state;
	logic [INDEX_W-1:0]  index;
	logic [INDEX_W-1:0]  flush_index;
	logic [TAG_W-1:0]    tag;
	logic                hit;
	logic                hit_q;
	logic                bus_request;
	logic                bus_rw;
	logic [31:0]         bus_address;
	logic [31:0]         bus_wdata;

	// One word per line
	assign index = i_req.address[INDEX_W+1:2];
	assign tag = i_req.address[31:INDEX_W+2];
	assign hit = valid[index] && (tag_mem[index] == tag);

	always_comb begin
		o_bus.request = bus_request;
		o_bus.rw = bus_rw;
		o_bus.address = bus_address;
		o_bus.wdata = bus_wdata;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			o_ready <= 1'b0;
			bus_request <= 1'b0;
			bus_rw <= 1'b0;
			valid <= '0;
			flush_index <= '0;
			o_hit <= 32'd0;
			o_miss <= 32'd0;
		end else begin
			o_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Request is still high while ready is out
					if (i_req.request && !o_ready) begin
						flush_index <= '0;
						state <= i_req.flush ? ST_FLUSH : ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (i_req.cacheable && !i_req.rw && hit) begin
						o_hit <= o_hit + 32'd1;
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end else begin
						if (i_req.cacheable && !i_req.rw) begin
							o_miss <= o_miss + 32'd1;
						end
						bus_request <= 1'b1;
						bus_rw <= i_req.rw;
						state <= ST_BUS;
					end
				end
				ST_BUS: begin
					if (i_bus_ready) begin
						bus_request <= 1'b0;
						bus_rw <= 1'b0;
						// Fill on a read miss or a write hit
						if (i_req.cacheable && (!i_req.rw || hit_q)) begin
							state <= ST_FILL;
						end else begin
							o_ready <= 1'b1;
							state <= ST_IDLE;
						end
					end
				end
				ST_FILL: begin
					valid[index] <= 1'b1;
					o_ready <= 1'b1;
					state <= ST_IDLE;
				end
				ST_FLUSH: begin
					valid[flush_index] <= 1'b0;
					flush_index <= flush_index + 1'b1;
					if (&flush_index) begin
						o_ready <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		case (state)
			ST_LOOKUP: begin
				hit_q <= hit;
				o_rdata <= data_mem[index];
				bus_address <= i_req.address;
				bus_wdata <= i_req.wdata;
			end
			ST_BUS: begin
				if (i_bus_ready) begin
					o_rdata <= i_bus_rdata;
				end
			end
			ST_FILL: begin
				tag_mem[index] <= tag;
				data_mem[index] <= i_req.rw ? i_req.wdata : o_rdata;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: mem_subsystem_top.f
+incdir+common
common/mem_stage_pkg.sv
memory/mem_access_fsm.sv
dcache/dcache_direct.sv
src/mem_subsystem_top.sv
testbench/mem_subsystem_assert.sv
testbench/tb_mem_subsystem.sv

// File: memory/mem_access_fsm.sv
// Data memory stage controller
`default_nettype none
`timescale 1ns/1ns

`include "mem_stage_macros.svh"

module mem_access_fsm
	import mem_stage_pkg::*;
(
	input  wire                i_clock,
	input  wire                i_rst,

	input  wire execute_data_t i_data,
	output logic               o_busy,
	output memory_data_t       o_data,

	output dcache_req_t        o_dc_req,
	input  wire                i_dc_ready,
	input  wire [31:0]         i_dc_rdata
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE_WORD,
		ST_RMW_READ,
		ST_RMW_WRITE,
		ST_FLUSH
	} state_t;

	state_t      state;
	logic        last_strobe;
	logic        out_strobe;
	logic [31:0] out_rd;
	logic [4:0]  out_inst_rd;

	logic        req_q;
	logic        rw_q;
	logic        flush_q;
	logic [31:0] wdata_q;

	logic        new_item;
	logic        is_mem;
	logic [4:0]  lane_shift;
	logic [31:0] rdata_shifted;
	logic [31:0] load_data;
	logic [31:0] store_mask;
	logic [31:0] merged_word;

	logic        complete;
	logic [31:0] result_rd;
	logic [4:0]  result_inst_rd;

	assign new_item = (i_data.strobe != last_strobe);
	assign is_mem = i_data.mem_read | i_data.mem_write | i_data.mem_flush;
	assign o_busy = new_item && is_mem;

	// Byte lane offset in bits
	assign lane_shift = {i_data.mem_address[1:0], 3'b000};

	always_comb begin
		o_dc_req.request = req_q;
		o_dc_req.rw = rw_q;
		o_dc_req.flush = flush_q;
		o_dc_req.cacheable = (i_data.mem_address[31:28] == `CACHEABLE_NIBBLE);
		o_dc_req.address = {i_data.mem_address[31:2], 2'b00};
		o_dc_req.wdata = wdata_q;
	end

	always_comb begin
		o_data.strobe = out_strobe;
		o_data.rd = out_rd;
		o_data.inst_rd = out_inst_rd;
	end

	// Load lane select and extension
	assign rdata_shifted = i_dc_rdata >> lane_shift;

	always_comb begin
		case (i_data.mem_width)
			`MEMW_1: begin
				load_data = {{24{i_data.mem_signed & rdata_shifted[7]}}, rdata_shifted[7:0]};
			end
			`MEMW_2: begin
				load_data = {{16{i_data.mem_signed & rdata_shifted[15]}}, rdata_shifted[15:0]};
			end
			default: begin
				load_data = i_dc_rdata;
			end
		endcase
	end

	// Narrow store merged into the word just read
	assign store_mask = ((i_data.mem_width == `MEMW_1) ? 32'h0000_00ff : 32'h0000_ffff)
		<< lane_shift;
	assign merged_word = (i_dc_rdata & ~store_mask) | ((i_data.rd << lane_shift) & store_mask);

	always_comb begin
		complete = 1'b0;
		result_rd = i_data.rd;
		result_inst_rd = i_data.inst_rd;
		case (state)
			ST_IDLE: begin
				complete = new_item && !is_mem;
			end
			ST_READ: begin
				complete = i_dc_ready;
				result_rd = load_data;
				result_inst_rd = i_data.mem_inst_rd;
			end
			ST_WRITE_WORD, ST_FLUSH, ST_RMW_WRITE: begin
				complete = i_dc_ready;
			end
			default: begin
				complete = 1'b0;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			last_strobe <= 1'b0;
			out_strobe <= 1'b0;
			req_q <= 1'b0;
			rw_q <= 1'b0;
			flush_q <= 1'b0;
		end else if (complete) begin
			out_strobe <= ~out_strobe;
			last_strobe <= i_data.strobe;
			req_q <= 1'b0;
			rw_q <= 1'b0;
			flush_q <= 1'b0;
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					// Only memory items get here
					if (new_item) begin
						req_q <= 1'b1;
						if (i_data.mem_read) begin
							state <= ST_READ;
						end else if (i_data.mem_write && i_data.mem_width == `MEMW_4) begin
							rw_q <= 1'b1;
							state <= ST_WRITE_WORD;
						end else if (i_data.mem_write) begin
							state <= ST_RMW_READ;
						end else begin
							flush_q <= 1'b1;
							state <= ST_FLUSH;
						end
					end
				end
				ST_RMW_READ: begin
					if (i_dc_ready) begin
						req_q <= 1'b0;
						state <= ST_RMW_WRITE;
					end
				end
				ST_RMW_WRITE: begin
					// Request stays low for one cycle between the two accesses
					if (!req_q) begin
						req_q <= 1'b1;
						rw_q <= 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && new_item) begin
			wdata_q <= i_data.rd;
		end else if (state == ST_RMW_READ && i_dc_ready) begin
			wdata_q <= merged_word;
		end
		if (complete) begin
			out_rd <= result_rd;
			out_inst_rd <= result_inst_rd;
		end
	end

endmodule

`default_nettype wire

// File: src/mem_subsystem_top.sv
// Memory stage with data cache
`default_nettype none
`timescale 1ns/1ns

module mem_subsystem_top
	import mem_stage_pkg::*;
(
	input  wire                i_clock,
	input  wire                i_rst,

	input  wire execute_data_t i_data,
	output logic               o_busy,
	output memory_data_t       o_data,

	output bus_req_t           o_bus,
	input  wire                i_bus_ready,
	input  wire [31:0]         i_bus_rdata,

	output logic [31:0]        o_dcache_hit,
	output logic [31:0]        o_dcache_miss
);

	dcache_req_t dc_req;
	logic        dc_ready;
	logic [31:0] dc_rdata;

	mem_access_fsm u_mem_access_fsm (
		.i_clock    (i_clock),
		.i_rst      (i_rst),
		.i_data     (i_data),
		.o_busy     (o_busy),
		.o_data     (o_data),
		.o_dc_req   (dc_req),
		.i_dc_ready (dc_ready),
		.i_dc_rdata (dc_rdata)
	);

	dcache_direct u_dcache_direct (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_req       (dc_req),
		.o_ready     (dc_ready),
		.o_rdata     (dc_rdata),
		.o_bus       (o_bus),
		.i_bus_ready (i_bus_ready),
		.i_bus_rdata (i_bus_rdata),
		.o_hit       (o_dcache_hit),
		.o_miss      (o_dcache_miss)
	);

endmodule

`default_nettype wire

// File: testbench/mem_subsystem_assert.sv
// Bus and strobe protocol checks
`default_nettype none
`timescale 1ns/1ns

module mem_subsystem_bind
	import mem_stage_pkg::*;
(
	input wire                i_clock,
	input wire                i_rst,
	input wire execute_data_t i_data,
	input wire                i_busy,
	input wire memory_data_t  i_result,
	input wire bus_req_t      i_bus,
	input wire                i_bus_ready
);

	// Held request keeps its fields until the ready pulse
	bus_held: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus.request && !i_bus_ready |=> $stable(i_bus))
		else $error("bus request changed while waiting for ready");

	bus_ready_with_request: assert property (@(posedge i_clock) disable iff (i_rst)
		i_bus_ready |-> i_bus.request)
		else $error("bus ready without a request");

	// Nothing pending right after a result when the input is unchanged
	idle_after_result: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_result.strobe != $past(i_result.strobe)) && (i_data.strobe == $past(i_data.strobe))
		|-> !i_busy)
		else $error("busy after a result with no new input");

endmodule

bind mem_subsystem_top mem_subsystem_bind u_mem_subsystem_bind (
	.i_clock     (i_clock),
	.i_rst       (i_rst),
	.i_data      (i_data),
	.i_busy      (o_busy),
	.i_result    (o_data),
	.i_bus       (o_bus),
	.i_bus_ready (i_bus_ready)
);

`default_nettype wire

// File: testbench/tb_mem_subsystem.sv
// Memory subsystem testbench
`default_nettype none
`timescale 1ns/1ns

`include "mem_stage_macros.svh"

module tb_mem_subsystem
	import mem_stage_pkg::*;
();

	localparam int NUM_DIRECTED = 15;
	localparam int NUM_RANDOM = 300;
	localparam int MEM_WORDS = 64;
	localparam logic [1:0] KIND_ALU = 2'd0;
	localparam logic [1:0] KIND_LOAD = 2'd1;
	localparam logic [1:0] KIND_STORE = 2'd2;
	localparam logic [1:0] KIND_FLUSH = 2'd3;

	logic          i_clock;
	logic          i_rst;
	execute_data_t i_data;
	logic          o_busy;
	memory_data_t  o_data;
	bus_req_t      o_bus;
	logic          i_bus_ready;
	logic [31:0]   i_bus_rdata;
	logic [31:0]   o_dcache_hit;
	logic [31:0]   o_dcache_miss;

	logic        [31:0] rand_state;
	logic               in_strobe;
	logic               prev_out_strobe;
	// Index 1 is the SDRAM region, index 0 the uncached region
	logic        [31:0] bus_mem [2][MEM_WORDS];
	logic        [31:0] exp_mem [2][MEM_WORDS];
	logic               line_valid [`DCACHE_LINES];
	logic        [31:0] line_addr [`DCACHE_LINES];
	logic        [31:0] exp_hit;
	logic        [31:0] exp_miss;

	mem_subsystem_top u_mem_subsystem_top (
		.i_clock       (i_clock),
		.i_rst         (i_rst),
		.i_data        (i_data),
		.o_busy        (o_busy),
		.o_data        (o_data),
		.o_bus         (o_bus),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.o_dcache_hit  (o_dcache_hit),
		.o_dcache_miss (o_dcache_miss)
	);

	function automatic logic [31:0] next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state ^ (rand_state >> 15);
	endfunction

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] make_address(input logic [3:0] nibble,
			input logic [5:0] word, input logic [1:0] off);
		return {nibble, 20'h0_0000, word, off};
	endfunction

	function automatic execute_data_t build_item(input logic [1:0] kind,
			input logic [1:0] width, input logic sgn, input logic [31:0] addr);
		execute_data_t item;
		logic [31:0]   r;
		item = '0;
		r = next_random();
		item.mem_read = (kind == KIND_LOAD);
		item.mem_write = (kind == KIND_STORE);
		item.mem_flush = (kind == KIND_FLUSH);
		item.mem_width = width;
		item.mem_signed = sgn;
		item.mem_address = addr;
		item.rd = next_random();
		item.inst_rd = r[4:0];
		item.mem_inst_rd = r[9:5];
		return item;
	endfunction

	function automatic execute_data_t random_item();
		logic [31:0] r;
		logic [1:0]  kind;
		logic [1:0]  width;
		logic [1:0]  off;
		logic [5:0]  word;
		logic [3:0]  nibble;
		int unsigned pick;
		r = next_random();
		pick = r % 20;
		kind = (pick < 4) ? KIND_ALU : (pick < 11) ? KIND_LOAD
			: (pick < 19) ? KIND_STORE : KIND_FLUSH;
		width = (r[8:7] == 2'd3) ? `MEMW_4 : r[8:7];
		if (width == `MEMW_1) begin
			off = r[10:9];
		end else if (width == `MEMW_2) begin
			off = {r[9], 1'b0};
		end else begin
			off = 2'b00;
		end
		nibble = (r[12:11] == 2'd0) ? 4'h1 : `CACHEABLE_NIBBLE;
		// A small hot set gives repeated hits
		word = r[13] ? {3'b000, r[16:14]} : r[19:14];
		return build_item(kind, width, r[20], make_address(nibble, word, off));
	endfunction

	function automatic logic [31:0] load_value(input logic [31:0] word, input logic [1:0] width,
			input logic sgn, input logic [1:0] off);
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] value;
		value = word;
		if (width == `MEMW_1) begin
			b = word[off*8 +: 8];
			value = sgn ? {{24{b[7]}}, b} : {24'd0, b};
		end else if (width == `MEMW_2) begin
			h = word[off*8 +: 16];
			value = sgn ? {{16{h[15]}}, h} : {16'd0, h};
		end
		return value;
	endfunction

	function automatic logic [31:0] store_value(input logic [31:0] word, input logic [31:0] data,
			input logic [1:0] width, input logic [1:0] off);
		logic [31:0] result;
		result = data;
		if (width == `MEMW_1) begin
			result = word;
			result[off*8 +: 8] = data[7:0];
		end else if (width == `MEMW_2) begin
			result = word;
			result[off*8 +: 16] = data[15:0];
		end
		return result;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got == expected)
		else abort_run($sformatf("Mismatch at %0t: %s = %h, expected %h", $time, what, got,
			expected));
	endtask

	// A read miss allocates the line in the cache copy
	task automatic model_lookup(input logic [31:0] waddr, input logic cacheable);
		int line;
		line = (waddr >> 2) % `DCACHE_LINES;
		if (cacheable) begin
			if (line_valid[line] && line_addr[line] == waddr) begin
				exp_hit = exp_hit + 32'd1;
			end else begin
				exp_miss = exp_miss + 32'd1;
				line_valid[line] = 1'b1;
				line_addr[line] = waddr;
			end
		end
	endtask

	task automatic run_item(input execute_data_t item);
		logic        cacheable;
		logic [5:0]  word;
		logic [31:0] waddr;
		logic [31:0] old_word;
		logic [31:0] exp_rd;
		logic [4:0]  exp_inst_rd;
		logic        is_mem;
		int          waited;
		int          i;
		cacheable = (item.mem_address[31:28] == `CACHEABLE_NIBBLE);
		word = item.mem_address[7:2];
		waddr = {item.mem_address[31:2], 2'b00};
		old_word = exp_mem[cacheable][word];
		is_mem = item.mem_read | item.mem_write | item.mem_flush;
		exp_rd = item.rd;
		exp_inst_rd = item.inst_rd;
		if (item.mem_read) begin
			model_lookup(waddr, cacheable);
			exp_rd = load_value(old_word, item.mem_width, item.mem_signed, item.mem_address[1:0]);
			exp_inst_rd = item.mem_inst_rd;
		end else if (item.mem_write) begin
			// Narrow stores read the word first
			if (item.mem_width != `MEMW_4) begin
				model_lookup(waddr, cacheable);
			end
			exp_mem[cacheable][word] = store_value(old_word, item.rd, item.mem_width,
				item.mem_address[1:0]);
		end else if (item.mem_flush) begin
			for (i = 0; i < `DCACHE_LINES; i++) begin
				line_valid[i] = 1'b0;
			end
		end
		in_strobe = ~in_strobe;
		item.strobe = in_strobe;
		@(posedge i_clock);
		i_data <= item;
		waited = 0;
		do begin
			@(negedge i_clock);
			waited++;
			if (waited == 1) begin
				check_value("o_busy", 32'(o_busy), 32'(is_mem));
			end
		end while (o_data.strobe == prev_out_strobe);
		prev_out_strobe = o_data.strobe;
		if (!is_mem) begin
			check_value("non-memory latency in cycles", waited - 1, 32'd1);
		end
		check_value("o_data.rd", o_data.rd, exp_rd);
		check_value("o_data.inst_rd", 32'(o_data.inst_rd), 32'(exp_inst_rd));
		check_value("o_dcache_hit", o_dcache_hit, exp_hit);
		check_value("o_dcache_miss", o_dcache_miss, exp_miss);
		if (item.mem_write) begin
			check_value($sformatf("bus memory at %h", waddr), bus_mem[cacheable][word],
				exp_mem[cacheable][word]);
		end
	endtask

	initial begin : clock_gen
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	initial begin : watchdog
		repeat ((NUM_DIRECTED + NUM_RANDOM) * 60 + 200) @(posedge i_clock);
		abort_run("Timeout: the DUT stopped returning results");
	end

	// Bus memory with 0 to 3 wait cycles
	initial begin : bus_memory
		bus_req_t    req;
		int unsigned waits;
		logic        slot;
		i_bus_ready = 1'b0;
		i_bus_rdata = 32'd0;
		forever begin
			@(negedge i_clock);
			if (o_bus.request && !i_rst) begin
				req = o_bus;
				slot = (req.address[31:28] == `CACHEABLE_NIBBLE);
				assert (req.address[27:8] == 20'd0 && req.address[1:0] == 2'b00
					&& (slot || req.address[31:28] == 4'h1))
				else abort_run($sformatf("Bus access outside the modeled memory at %h",
					req.address));
				waits = next_random() % 4;
				repeat (waits) @(negedge i_clock);
				@(posedge i_clock);
				i_bus_ready <= 1'b1;
				i_bus_rdata <= bus_mem[slot][req.address[7:2]];
				if (req.rw) begin
					bus_mem[slot][req.address[7:2]] = req.wdata;
				end
				@(posedge i_clock);
				i_bus_ready <= 1'b0;
			end
		end
	end

	initial begin : stimulus
		int i;
		rand_state = 32'h3d10_ff37;
		in_strobe = 1'b0;
		prev_out_strobe = 1'b0;
		exp_hit = 32'd0;
		exp_miss = 32'd0;
		for (i = 0; i < `DCACHE_LINES; i++) begin
			line_valid[i] = 1'b0;
			line_addr[i] = 32'd0;
		end
		for (i = 0; i < MEM_WORDS; i++) begin
			bus_mem[0][i] = fill_word(make_address(4'h1, 6'(i), 2'b00));
			bus_mem[1][i] = fill_word(make_address(`CACHEABLE_NIBBLE, 6'(i), 2'b00));
			exp_mem[0][i] = bus_mem[0][i];
			exp_mem[1][i] = bus_mem[1][i];
		end
		i_rst = 1'b1;
		i_data = '0;
		repeat (3) @(posedge i_clock);
		i_rst <= 1'b0;
		// Miss then hit per word
		for (i = 0; i < 4; i++) begin
			repeat (2) run_item(build_item(KIND_LOAD, `MEMW_4, 1'b0,
				make_address(`CACHEABLE_NIBBLE, 6'(i), 2'b00)));
		end
		repeat (2) run_item(build_item(KIND_LOAD, `MEMW_4, 1'b0,
			make_address(4'h1, 6'd5, 2'b00)));
		run_item(build_item(KIND_FLUSH, `MEMW_4, 1'b0, 32'd0));
		for (i = 0; i < 4; i++) begin
			run_item(build_item(KIND_LOAD, `MEMW_4, 1'b0,
				make_address(`CACHEABLE_NIBBLE, 6'(i), 2'b00)));
		end
		for (i = 0; i < NUM_RANDOM; i++) begin
			run_item(random_item());
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
